/* list.f */
+incdir+logic
logic/pmp_pkg.sv
logic/pmp_entry_match.sv
logic/pmp_csr_apb.sv
logic/pmp_priority_check.sv
logic/pmp_checker.sv
logic/pmp_top.sv
tb/pmp_tb.sv

/* logic/pmp_checker.sv */
// PMP request pipeline with entry chain, priority check and registered response
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_checker (
  input  logic                cpuclk,
  input  logic                reset,
  input  pmp_pkg::pmp_req_t   req,
  input  pmp_pkg::pmp_cfg_t   pmp_cfg  [`PMP_ENTRIES],
  input  pmp_pkg::pmp_addr_t  pmp_addr [`PMP_ENTRIES],
  output pmp_pkg::pmp_resp_t  resp
);

  logic [`PMP_PA_WIDTH-`PMP_PAGE_BITS-1:0] pa_page;
  logic [`PMP_ENTRIES:0]                   ge_chain;  // Bound handed up the chain
  logic [`PMP_ENTRIES-1:0]                 hits;
  logic                                    fault;
  logic                                    hit;
  logic [$clog2(`PMP_ENTRIES)-1:0]         index;

  assign pa_page = req.pa[`PMP_PA_WIDTH-1:`PMP_PAGE_BITS];  // Page number only

  // ----------------------------------------------------------------------
  // Entry chain
  // ----------------------------------------------------------------------
  assign ge_chain[0] = 1'b1;   // TOR entry 0 starts at zero

  for (genvar i = 0; i < `PMP_ENTRIES; i++)
  begin : g_entry
    pmp_entry_match u_match (
      .addr_match_mode (pmp_cfg[i].mode),
      .addr_ge_bottom  (ge_chain[i]),
      .pa_page         (pa_page),
      .pmpaddr         (pmp_addr[i]),
      .addr_ge_top     (ge_chain[i+1]),
      .hit             (hits[i])
    );
  end

  pmp_priority_check u_prio (
    .hits    (hits),
    .pmp_cfg (pmp_cfg),
    .acc     (req.acc),
    .priv_m  (req.priv_m),
    .fault   (fault),
    .hit     (hit),
    .index   (index)
  );

  // ----------------------------------------------------------------------
  // Response stage one clock after the request
  // ----------------------------------------------------------------------
  always_ff @(posedge cpuclk)
  begin
    if (reset)
      resp.valid <= 1'b0;
    else
      resp.valid <= req.valid;
    resp.fault <= fault;       // Result fields load every clock
    resp.hit   <= hit;
    resp.index <= index;
  end

endmodule

/* logic/pmp_csr_apb.sv */
// PMP register file on APB: pmpcfg and pmpaddr storage with lock rules
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_csr_apb (
  input  logic                cpuclk,
  input  logic                reset,
  input  pmp_pkg::apb_req_t   apb_req,
  output pmp_pkg::apb_resp_t  apb_resp,
  output pmp_pkg::pmp_cfg_t   pmp_cfg  [`PMP_ENTRIES],
  output pmp_pkg::pmp_addr_t  pmp_addr [`PMP_ENTRIES]
);

  localparam int CFG_WORDS = `PMP_ENTRIES / 4;      // Four entries per word
  localparam int IDX_W     = $clog2(`PMP_ENTRIES);

  pmp_pkg::pmp_cfg_word_u cfg_q  [CFG_WORDS];  // pmpcfg0, pmpcfg1
  pmp_pkg::pmp_addr_t     addr_q [`PMP_ENTRIES];

  logic                    access;
  logic                    wr_en;
  logic                    cfg_hit;
  logic                    cfg_idx;
  logic [`PMP_APB_AW-1:0]  addr_off;
  logic                    addr_hit;
  logic [IDX_W-1:0]        addr_idx;
  logic [`PMP_ENTRIES-1:0] tor_lock;    // Entry i+1 locked in TOR
  logic [`PMP_ENTRIES-1:0] addr_lock;
  pmp_pkg::pmp_cfg_word_u  wr_word;
  logic [31:0]             rdata;

  // ----------------------------------------------------------------------
  // Offset decode
  // ----------------------------------------------------------------------
  assign access = apb_req.psel & apb_req.penable;  // Access phase
  assign wr_en  = access & apb_req.pwrite;

  // 0x00 and 0x04
  assign cfg_hit = (apb_req.paddr[`PMP_APB_AW-1:3] == '0) && (apb_req.paddr[1:0] == 2'b00);
  assign cfg_idx = apb_req.paddr[2];

  // 0x10 to 0x2C, word aligned
  assign addr_off = apb_req.paddr - 8'h10;
  assign addr_hit = (apb_req.paddr >= 8'h10) && (apb_req.paddr[1:0] == 2'b00) &&
                    (addr_off[`PMP_APB_AW-1:2] < `PMP_ENTRIES);
  assign addr_idx = addr_off[IDX_W+1:2];

  // ----------------------------------------------------------------------
  // Entry views and lock vectors
  // ----------------------------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < `PMP_ENTRIES; i++)
    begin
      pmp_cfg[i]  = cfg_q[i / 4].entry[i % 4];
      pmp_addr[i] = addr_q[i];
    end
  end

  always_comb
  begin
    tor_lock = '0;                               // Last entry has no successor
    for (int i = 1; i < `PMP_ENTRIES; i++)
    begin
      tor_lock[i-1] = pmp_cfg[i].lock && (pmp_cfg[i].mode == pmp_pkg::TOR);
    end
    for (int i = 0; i < `PMP_ENTRIES; i++)
    begin
      addr_lock[i] = pmp_cfg[i].lock | tor_lock[i];
    end
  end

  // Write data with reserved fields forced low
  always_comb
  begin
    wr_word.raw = apb_req.pwdata;
    for (int b = 0; b < 4; b++)
    begin
      wr_word.entry[b].rsvd = 2'b00;
    end
  end

  // ----------------------------------------------------------------------
  // Register update
  // ----------------------------------------------------------------------
  always_ff @(posedge cpuclk)
  begin
    if (reset)
    begin
      for (int w = 0; w < CFG_WORDS; w++)
      begin
        cfg_q[w] <= '0;                          // All entries OFF, unlocked
      end
      for (int i = 0; i < `PMP_ENTRIES; i++)
      begin
        addr_q[i] <= '0;
      end
    end
    else
    begin
      if (wr_en && cfg_hit)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (!cfg_q[cfg_idx].entry[b].lock)       // Locked bytes hold
          begin
            cfg_q[cfg_idx].entry[b] <= wr_word.entry[b];
          end
        end
      end
      if (wr_en && addr_hit && !addr_lock[addr_idx])
      begin
        addr_q[addr_idx] <= apb_req.pwdata[$bits(pmp_pkg::pmp_addr_t)-1:0];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read data and response
  // ----------------------------------------------------------------------
  always_comb
  begin
    rdata = '0;                                  // Unmapped reads as zero
    if (cfg_hit)
    begin
      rdata = cfg_q[cfg_idx].raw;
    end
    else if (addr_hit)
    begin
      rdata = {{(32 - $bits(pmp_pkg::pmp_addr_t)){1'b0}}, addr_q[addr_idx]};
    end
  end

  // Zero wait states
  assign apb_resp.pready  = access;
  assign apb_resp.pslverr = access & ~(cfg_hit | addr_hit);
  assign apb_resp.prdata  = rdata;

endmodule

/* logic/pmp_entry_match.sv */
// PMP entry comparator for OFF, TOR and NAPOT page match with chained bottom bound
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_entry_match (
  input  pmp_pkg::pmp_mode_e                     addr_match_mode,
  input  logic                                   addr_ge_bottom,  // From previous entry
  input  logic [`PMP_PA_WIDTH-`PMP_PAGE_BITS-1:0] pa_page,
  input  pmp_pkg::pmp_addr_t                     pmpaddr,
  output logic                                   addr_ge_top,     // To next entry
  output logic                                   hit
);

  localparam int PPN_W = `PMP_PA_WIDTH - `PMP_PAGE_BITS;  // 28 compared bits

  logic [PPN_W:0]   comp_diff;    // Borrow in top bit
  logic             addr_lt_top;
  logic             tor_match;
  logic [PPN_W-1:0] napot_mask;
  logic             napot_match;

  // ----------------------------------------------------------------------
  // TOR match for bottom <= page < pmpaddr
  // ----------------------------------------------------------------------
  // Borrow of the one subtractor means below top
  assign comp_diff   = {1'b0, pa_page} - {1'b0, pmpaddr[PPN_W:1]};
  assign addr_lt_top = comp_diff[PPN_W];
  assign tor_match   = addr_ge_bottom & addr_lt_top;

  // Next entry's bottom bound
  assign addr_ge_top = ~addr_lt_top;

  // ----------------------------------------------------------------------
  // NAPOT size from the trailing ones of pmpaddr
  // ----------------------------------------------------------------------
  // Bit 0 clear gives 4 KB and each extra trailing one doubles the region.
  // A mask bit drops once every pmpaddr bit at or below it is set.
  // All 28 trailing ones clear the whole mask for 1 TB.
  always_comb
  begin
    logic ones_run;
    ones_run = 1'b1;
    for (int i = 0; i < PPN_W; i++)
    begin
      ones_run      = ones_run & pmpaddr[i];
      napot_mask[i] = ~ones_run;       // Cleared bits are don't care
    end
  end

  assign napot_match = (napot_mask & pa_page) == (napot_mask & pmpaddr[PPN_W:1]);

  // ----------------------------------------------------------------------
  // Mode select
  // ----------------------------------------------------------------------
  always_comb
  begin
    case (addr_match_mode)
      pmp_pkg::OFF:   hit = 1'b0;
      pmp_pkg::TOR:   hit = tor_match;
      pmp_pkg::NA4:   hit = 1'b0;         // Region smaller than a page
      pmp_pkg::NAPOT: hit = napot_match;
      default:        hit = 1'b0;
    endcase
  end

endmodule

/* logic/pmp_pkg.sv */
// PMP shared types: entry config, config word, request, response and APB
`include "pmp_settings.svh"

package pmp_pkg;

  // ----------------------------------------------------------------------
  // Entry configuration
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    OFF   = 2'b00,  // Entry disabled
    TOR   = 2'b01,  // Top of range, bottom from previous entry
    NA4   = 2'b10,  // Kept for encoding, cannot hit at page size
    NAPOT = 2'b11   // Naturally aligned power of two
  } pmp_mode_e;

  typedef struct packed {
    logic      lock;   // Also binds machine mode
    logic [1:0] rsvd;  // Always stored as zero
    pmp_mode_e mode;
    logic      x;
    logic      w;
    logic      r;
  } pmp_cfg_t;

  // One pmpcfg word, seen raw by APB and per entry by lock logic
  typedef union packed {
    logic [31:0]        raw;
    pmp_cfg_t [3:0]     entry;  // entry[0] in bits 7:0
  } pmp_cfg_word_u;

  // PA bits 39:11, bit 0 carries the NAPOT size
  typedef logic [`PMP_PA_WIDTH-`PMP_PAGE_BITS:0] pmp_addr_t;

  // ----------------------------------------------------------------------
  // Request side
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    READ  = 2'b00,
    WRITE = 2'b01,
    EXEC  = 2'b10
  } pmp_acc_e;

  typedef struct packed {
    logic                     valid;
    logic [`PMP_PA_WIDTH-1:0] pa;
    pmp_acc_e                 acc;
    logic                     priv_m;  // Machine mode
  } pmp_req_t;

  typedef struct packed {
    logic                            valid;
    logic                            fault;
    logic                            hit;    // Any entry matched
    logic [$clog2(`PMP_ENTRIES)-1:0] index;  // Deciding entry
  } pmp_resp_t;

  // ----------------------------------------------------------------------
  // APB
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`PMP_APB_AW-1:0] paddr;
    logic [31:0]            pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_resp_t;

endpackage

/* logic/pmp_priority_check.sv */
// PMP priority select and permission check for one access
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_priority_check (
  input  logic [`PMP_ENTRIES-1:0]          hits,
  input  pmp_pkg::pmp_cfg_t                pmp_cfg [`PMP_ENTRIES],
  input  pmp_pkg::pmp_acc_e                acc,
  input  logic                             priv_m,
  output logic                             fault,
  output logic                             hit,
  output logic [$clog2(`PMP_ENTRIES)-1:0]  index
);

  localparam int IDX_W = $clog2(`PMP_ENTRIES);

  pmp_pkg::pmp_cfg_t sel_cfg;   // Config of the deciding entry
  logic              perm;      // r, w or x granted
  logic              allowed;

  // ----------------------------------------------------------------------
  // Lowest hitting entry wins
  // ----------------------------------------------------------------------
  always_comb
  begin
    hit   = 1'b0;
    index = '0;
    // Walk downward so the lowest index is written last
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--)
    begin
      if (hits[i])
      begin
        hit   = 1'b1;
        index = IDX_W'(i);
      end
    end
  end

  assign sel_cfg = pmp_cfg[index];

  // ----------------------------------------------------------------------
  // Permission decode
  // ----------------------------------------------------------------------
  always_comb
  begin
    case (acc)
      pmp_pkg::READ:  perm = sel_cfg.r;
      pmp_pkg::WRITE: perm = sel_cfg.w;
      pmp_pkg::EXEC:  perm = sel_cfg.x;
      default:        perm = 1'b0;      // Unused encoding
    endcase
  end

  always_comb
  begin
    if (hit)
    begin
      // Unlocked entries only bind S and U modes
      allowed = perm | (priv_m & ~sel_cfg.lock);
    end
    else
    begin
      allowed = priv_m;                 // No match: M passes, others fault
    end
  end

  assign fault = ~allowed;

endmodule

/* logic/pmp_settings.svh */
// PMP checker settings: address widths, entry count and APB width
`ifndef PMP_SETTINGS_SVH
`define PMP_SETTINGS_SVH

// ----------------------------------------------------------------------
// Physical address
// ----------------------------------------------------------------------
`define PMP_PA_WIDTH   40   // Physical address bits
`define PMP_PAGE_BITS  12   // 4 KB granularity, low bits never compared

// ----------------------------------------------------------------------
// Entry array
// ----------------------------------------------------------------------
`define PMP_ENTRIES    8    // Four entries per pmpcfg word

// ----------------------------------------------------------------------
// Register port
// ----------------------------------------------------------------------
`define PMP_APB_AW     8    // Byte offset width of the APB window

`endif

/* logic/pmp_top.sv */
// PMP top level: APB register block feeding the request checker
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_top (
  input  logic                cpuclk,
  input  logic                reset,
  input  pmp_pkg::apb_req_t   apb_req,
  output pmp_pkg::apb_resp_t  apb_resp,
  input  pmp_pkg::pmp_req_t   req,
  output pmp_pkg::pmp_resp_t  resp
);

  // Register outputs straight into the comparators
  pmp_pkg::pmp_cfg_t  pmp_cfg  [`PMP_ENTRIES];
  pmp_pkg::pmp_addr_t pmp_addr [`PMP_ENTRIES];

  // ----------------------------------------------------------------------
  // Register file
  // ----------------------------------------------------------------------
  pmp_csr_apb u_csr (
    .cpuclk   (cpuclk),
    .reset    (reset),
    .apb_req  (apb_req),
    .apb_resp (apb_resp),
    .pmp_cfg  (pmp_cfg),
    .pmp_addr (pmp_addr)
  );

  // ----------------------------------------------------------------------
  // Checker pipeline
  // ----------------------------------------------------------------------
  pmp_checker u_checker (
    .cpuclk   (cpuclk),
    .reset    (reset),
    .req      (req),
    .pmp_cfg  (pmp_cfg),
    .pmp_addr (pmp_addr),
    .resp     (resp)
  );

endmodule

/* tb/pmp_tb.sv */
// PMP checker testbench with table-driven APB and request checks against a reference model
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_tb;

  localparam int         APB_TIMEOUT = 16;  // Clocks allowed for pready
  localparam int         PIPE_LEN    = 48;  // Back-to-back random requests
  localparam logic [1:0] K_WR        = 2'd0;
  localparam logic [1:0] K_RD        = 2'd1;
  localparam logic [1:0] K_CHK       = 2'd2;
  localparam pmp_pkg::pmp_acc_e RD = pmp_pkg::READ;
  localparam pmp_pkg::pmp_acc_e WR = pmp_pkg::WRITE;
  localparam pmp_pkg::pmp_acc_e EX = pmp_pkg::EXEC;

  typedef struct packed {
    logic [2:0]        test;    // Behavior group
    logic [1:0]        kind;
    logic [39:0]       pa;      // Request address or APB offset in low byte
    logic [31:0]       data;    // Write data or expected read data
    pmp_pkg::pmp_acc_e acc;
    logic              priv_m;
    logic              err;     // Expected pslverr
    logic              fault;
    logic              hit;
    logic [2:0]        index;
  } step_t;

  logic               cpuclk;
  logic               reset;
  pmp_pkg::apb_req_t  apb_req;
  pmp_pkg::apb_resp_t apb_resp;
  pmp_pkg::pmp_req_t  req;
  pmp_pkg::pmp_resp_t resp;

  step_t              table_q [$];
  pmp_pkg::pmp_cfg_t  sh_cfg  [`PMP_ENTRIES];  // Model copy of the programmed entries
  pmp_pkg::pmp_addr_t sh_addr [`PMP_ENTRIES];
  string              test_name [1:6];
  logic [31:0]        lfsr;
  logic [2:0]         cur_test;
  logic               timed_out;
  int                 errors;
  int                 test_errors;
  int                 checks;
  int                 tests_run;
  int                 tests_failed;

  pmp_top UUT (
    .cpuclk   (cpuclk),
    .reset    (reset),
    .apb_req  (apb_req),
    .apb_resp (apb_resp),
    .req      (req),
    .resp     (resp)
  );

  initial cpuclk = 1'b0;
  always #4 cpuclk = ~cpuclk;  // 8 ns period

  // ----------------------------------------------------------------------
  // Random source and table building
  // ----------------------------------------------------------------------
  function automatic logic lfsr_step();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb)
      lfsr = lfsr ^ 32'h8020_0003;      // Taps 32, 22, 2, 1
    return lsb;
  endfunction

  function automatic logic [39:0] rand_bits(input int n);
    logic [39:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[38:0], lfsr_step()};       // One step per bit
    return v;
  endfunction

  function automatic void add_apb(input logic [1:0] kind, input logic [7:0] off,
                                  input logic [31:0] data, input logic err);
    step_t s;
    s      = '0;
    s.test = cur_test;
    s.kind = kind;
    s.pa   = {32'h0, off};
    s.data = data;
    s.err  = err;
    table_q.push_back(s);
  endfunction

  function automatic void add_check(input logic [39:0] pa, input pmp_pkg::pmp_acc_e acc,
                                    input logic priv_m, input logic fault, input logic hit,
                                    input logic [2:0] index);
    step_t s;
    s        = '0;
    s.test   = cur_test;
    s.kind   = K_CHK;
    s.pa     = pa;
    s.acc    = acc;
    s.priv_m = priv_m;
    s.fault  = fault;
    s.hit    = hit;
    s.index  = index;
    table_q.push_back(s);
  endfunction

  function automatic void build_table();
    cur_test = 3'd1;                               // Register map
    add_apb(K_RD, 8'h00, 32'h0, 1'b0);
    add_apb(K_RD, 8'h04, 32'h0, 1'b0);
    for (int i = 0; i < `PMP_ENTRIES; i++)
      add_apb(K_RD, 8'(8'h10 + 4 * i), 32'h0, 1'b0);  // Every pmpaddr
    add_apb(K_WR, 8'h04, 32'h6767_6767, 1'b0);     // Reserved bits set
    add_apb(K_RD, 8'h04, 32'h0707_0707, 1'b0);
    add_apb(K_WR, 8'h2C, 32'hFFFF_FFFF, 1'b0);
    add_apb(K_RD, 8'h2C, 32'h1FFF_FFFF, 1'b0);     // 29 bits kept
    add_apb(K_WR, 8'h08, 32'h1234_5678, 1'b1);     // Unmapped
    add_apb(K_RD, 8'h08, 32'h0, 1'b1);
    add_apb(K_WR, 8'h30, 32'h0000_0ABC, 1'b1);
    add_apb(K_WR, 8'h11, 32'h0000_0DEF, 1'b1);     // Misaligned
    add_apb(K_RD, 8'h00, 32'h0, 1'b0);
    add_apb(K_RD, 8'h10, 32'h0, 1'b0);
    add_apb(K_RD, 8'h2C, 32'h1FFF_FFFF, 1'b0);
    add_apb(K_RD, 8'h04, 32'h0707_0707, 1'b0);
    add_apb(K_WR, 8'h04, 32'h0, 1'b0);
    add_apb(K_WR, 8'h2C, 32'h0, 1'b0);
    cur_test = 3'd2;                               // TOR over pages 0..FF and 100..17F
    add_apb(K_WR, 8'h10, 32'h0000_0200, 1'b0);
    add_apb(K_WR, 8'h14, 32'h0000_0300, 1'b0);
    add_apb(K_WR, 8'h00, 32'h0000_0B09, 1'b0);
    add_apb(K_RD, 8'h00, 32'h0000_0B09, 1'b0);
    add_check(40'h00_0000_0000, RD, 1'b0, 1'b0, 1'b1, 3'd0);
    add_check(40'h00_000F_F000, RD, 1'b0, 1'b0, 1'b1, 3'd0);
    add_check(40'h00_0010_0000, RD, 1'b0, 1'b0, 1'b1, 3'd1);
    add_check(40'h00_0017_FFFF, RD, 1'b0, 1'b0, 1'b1, 3'd1);
    add_check(40'h00_0018_0000, RD, 1'b0, 1'b1, 1'b0, 3'd0);
    add_check(40'h00_0005_0000, WR, 1'b0, 1'b1, 1'b1, 3'd0);
    cur_test = 3'd3;                               // NAPOT 4 KB, 64 KB, 1 GB, NA4
    add_apb(K_WR, 8'h20, 32'h0000_2000, 1'b0);
    add_apb(K_WR, 8'h24, 32'h0000_400F, 1'b0);
    add_apb(K_WR, 8'h28, 32'h000B_FFFF, 1'b0);
    add_apb(K_WR, 8'h2C, 32'h0000_6000, 1'b0);
    add_apb(K_WR, 8'h04, 32'h171F_1B19, 1'b0);
    add_check(40'h00_0100_0000, RD, 1'b0, 1'b0, 1'b1, 3'd4);
    add_check(40'h00_0100_0FFF, RD, 1'b0, 1'b0, 1'b1, 3'd4);
    add_check(40'h00_0100_1000, RD, 1'b0, 1'b1, 1'b0, 3'd0);
    add_check(40'h00_00FF_F000, RD, 1'b0, 1'b1, 1'b0, 3'd0);
    add_check(40'h00_0200_0000, RD, 1'b0, 1'b0, 1'b1, 3'd5);
    add_check(40'h00_0200_FFFF, RD, 1'b0, 1'b0, 1'b1, 3'd5);
    add_check(40'h00_0201_0000, RD, 1'b0, 1'b1, 1'b0, 3'd0);
    add_check(40'h00_01FF_F000, RD, 1'b0, 1'b1, 1'b0, 3'd0);
    add_check(40'h00_4000_0000, RD, 1'b0, 1'b0, 1'b1, 3'd6);
    add_check(40'h00_7FFF_FFFF, RD, 1'b0, 1'b0, 1'b1, 3'd6);
    add_check(40'h00_8000_0000, RD, 1'b0, 1'b1, 1'b0, 3'd0);
    add_check(40'h00_3FFF_F000, RD, 1'b0, 1'b1, 1'b0, 3'd0);
    add_check(40'h00_0300_0000, RD, 1'b0, 1'b1, 1'b0, 3'd0);  // NA4 page
    cur_test = 3'd4;                               // Entry 2 shadows entry 5 with x only
    add_apb(K_WR, 8'h18, 32'h0000_400F, 1'b0);
    add_apb(K_WR, 8'h00, 32'h001C_0B09, 1'b0);
    add_check(40'h00_0200_0000, RD, 1'b0, 1'b1, 1'b1, 3'd2);
    add_check(40'h00_0200_0000, EX, 1'b0, 1'b0, 1'b1, 3'd2);
    add_check(40'h00_0100_0000, WR, 1'b0, 1'b1, 1'b1, 3'd4);
    add_check(40'h00_0100_0000, EX, 1'b0, 1'b1, 1'b1, 3'd4);
    add_check(40'h00_4000_1000, WR, 1'b0, 1'b0, 1'b1, 3'd6);
    add_check(40'h00_4000_1000, EX, 1'b0, 1'b0, 1'b1, 3'd6);
    add_check(40'h00_0010_0000, EX, 1'b0, 1'b1, 1'b1, 3'd1);
    add_check(40'h00_8000_0000, RD, 1'b1, 1'b0, 1'b0, 3'd0);
    add_check(40'h00_8000_0000, RD, 1'b0, 1'b1, 1'b0, 3'd0);
    add_check(40'h00_0100_0000, WR, 1'b1, 1'b0, 1'b1, 3'd4);  // Unlocked entry lets M pass
    cur_test = 3'd5;                               // Locks
    add_apb(K_WR, 8'h1C, 32'h0000_6000, 1'b0);
    add_apb(K_WR, 8'h00, 32'h891C_0B09, 1'b0);     // Entry 3 locked TOR
    add_apb(K_RD, 8'h00, 32'h891C_0B09, 1'b0);
    add_apb(K_WR, 8'h18, 32'h0000_1234, 1'b0);
    add_apb(K_RD, 8'h18, 32'h0000_400F, 1'b0);
    add_apb(K_WR, 8'h1C, 32'h0000_7000, 1'b0);
    add_apb(K_RD, 8'h1C, 32'h0000_6000, 1'b0);
    add_apb(K_WR, 8'h00, 32'h009C_0B09, 1'b0);     // Lock entry 2
    add_apb(K_RD, 8'h00, 32'h899C_0B09, 1'b0);
    add_apb(K_WR, 8'h00, 32'h001F_0B09, 1'b0);
    add_apb(K_RD, 8'h00, 32'h899C_0B09, 1'b0);
    add_check(40'h00_0200_0000, RD, 1'b1, 1'b1, 1'b1, 3'd2);
    add_check(40'h00_0200_0000, EX, 1'b1, 1'b0, 1'b1, 3'd2);
    add_check(40'h00_0280_0000, WR, 1'b1, 1'b1, 1'b1, 3'd3);
    add_check(40'h00_0280_0000, RD, 1'b1, 1'b0, 1'b1, 3'd3);
    add_check(40'h00_0201_0000, RD, 1'b0, 1'b0, 1'b1, 3'd3);
  endfunction

  // ----------------------------------------------------------------------
  // Reference model of the matching and permission rules
  // ----------------------------------------------------------------------
  function automatic pmp_pkg::pmp_resp_t model_resp(input pmp_pkg::pmp_req_t r);
    pmp_pkg::pmp_resp_t m;
    pmp_pkg::pmp_cfg_t  c;
    logic [27:0]        page;
    logic [27:0]        top;
    logic [27:0]        bottom;
    logic               h;
    logic               perm;
    int                 k;
    m       = '0;
    m.valid = r.valid;
    page    = r.pa[39:12];
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--)    // Lowest index ends up deciding
    begin
      top    = sh_addr[i][28:1];
      bottom = (i == 0) ? 28'd0 : sh_addr[i-1][28:1];
      k      = 0;
      while (k < 28 && sh_addr[i][k])
        k++;                                       // Region is 2^k pages
      case (sh_cfg[i].mode)
        pmp_pkg::TOR:   h = (page >= bottom) && (page < top);
        pmp_pkg::NAPOT: h = (page >> k) == (top >> k);
        default:        h = 1'b0;
      endcase
      if (h)
      begin
        m.hit   = 1'b1;
        m.index = 3'(i);
      end
    end
    c = sh_cfg[m.index];
    case (r.acc)
      pmp_pkg::READ:  perm = c.r;
      pmp_pkg::WRITE: perm = c.w;
      default:        perm = c.x;
    endcase
    m.fault = m.hit ? ~(perm | (r.priv_m & ~c.lock)) : ~r.priv_m;
    return m;
  endfunction

  // ----------------------------------------------------------------------
  // Bus and request tasks
  // ----------------------------------------------------------------------
  task automatic note_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic apb_transfer(input logic wr, input logic [7:0] off, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    int waits;
    @(negedge cpuclk);
    apb_req.psel    = 1'b1;                        // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = off;
    apb_req.pwdata  = wdata;
    @(negedge cpuclk);
    apb_req.penable = 1'b1;
    #2;
    waits = 0;
    while (!apb_resp.pready && waits < APB_TIMEOUT)
    begin
      @(negedge cpuclk);
      #2;                                          // Mid low phase
      waits++;
    end
    rdata = apb_resp.prdata;
    err   = apb_resp.pslverr;
    if (!apb_resp.pready)
    begin
      $display("APB transfer to offset 0x%02h got no pready within %0d clocks", off, waits);
      timed_out = 1'b1;
    end
    @(negedge cpuclk);                             // Completing edge has passed
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] off, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, off, data, rdata, err);
    checks++;
    if (!timed_out && err !== exp_err)
      note_mismatch($sformatf("write 0x%02h pslverr %b, expected %b", off, err, exp_err));
  endtask

  task automatic apb_read(input logic [7:0] off, input logic [31:0] exp_data,
                          input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b0, off, 32'h0, rdata, err);
    checks++;
    if (!timed_out && (rdata !== exp_data || err !== exp_err))
      note_mismatch($sformatf("read 0x%02h gave %h/%b, expected %h/%b",
                              off, rdata, err, exp_data, exp_err));
  endtask

  task automatic compare_resp(input pmp_pkg::pmp_resp_t exp, input logic [39:0] pa);
    checks++;
    if (resp.valid !== exp.valid || (exp.valid && resp !== exp))
      note_mismatch($sformatf("pa %h valid/fault/hit/index %b %b %b %0d, expected %b %b %b %0d",
                              pa, resp.valid, resp.fault, resp.hit, resp.index,
                              exp.valid, exp.fault, exp.hit, exp.index));
  endtask

  task automatic check_request(input step_t s);
    pmp_pkg::pmp_resp_t exp;
    exp = {1'b1, s.fault, s.hit, s.index};
    @(negedge cpuclk);
    req.valid  = 1'b1;
    req.pa     = s.pa;
    req.acc    = s.acc;
    req.priv_m = s.priv_m;
    @(negedge cpuclk);                             // One clock of latency
    req.valid = 1'b0;
    compare_resp(exp, s.pa);
  endtask

  task automatic apply_reset();
    @(negedge cpuclk);
    reset = 1'b1;
    repeat (8) @(posedge cpuclk);
    @(negedge cpuclk);
    reset = 1'b0;
    checks++;
    if (resp.valid !== 1'b0 || apb_resp.pready !== 1'b0 || apb_resp.pslverr !== 1'b0)
      note_mismatch("outputs not idle after reset");
  endtask

  // Fixed config for the random run covering TOR, NAPOT, locks and gaps
  task automatic load_model_config();
    for (int i = 0; i < `PMP_ENTRIES; i++)
    begin
      sh_cfg[i]  = '0;
      sh_addr[i] = '0;
    end
    sh_cfg[0]  = 8'h1B;                            // NAPOT 256 GB at 0 with rw
    sh_addr[0] = 29'h03FF_FFFF;
    sh_cfg[1]  = 8'h89;                            // Locked TOR up to 512 GB with r
    sh_addr[1] = 29'h1000_0000;
    sh_cfg[2]  = 8'h9C;                            // Locked NAPOT 64 GB with x
    sh_addr[2] = 29'h18FF_FFFF;
    sh_cfg[3]  = 8'h0F;                            // TOR above entry 2 base with rwx
    sh_addr[3] = 29'h1E00_0000;
    for (int i = 0; i < `PMP_ENTRIES; i++)
      apb_write(8'(8'h10 + 4 * i), 32'(sh_addr[i]), 1'b0);
    apb_write(8'h00, {sh_cfg[3], sh_cfg[2], sh_cfg[1], sh_cfg[0]}, 1'b0);
    apb_write(8'h04, {sh_cfg[7], sh_cfg[6], sh_cfg[5], sh_cfg[4]}, 1'b0);
  endtask

  task automatic run_pipeline();
    pmp_pkg::pmp_resp_t exp;
    logic [39:0]        abits;
    exp = '0;                                      // Nothing in flight yet
    for (int n = 0; n <= PIPE_LEN; n++)
    begin
      @(negedge cpuclk);
      compare_resp(exp, req.pa);                   // Request from the last clock
      if (n < PIPE_LEN)
      begin
        req.pa     = rand_bits(40);
        abits      = rand_bits(2);
        req.acc    = (abits[1:0] == 2'b11) ? RD : pmp_pkg::pmp_acc_e'(abits[1:0]);
        req.priv_m = lfsr_step();
        req.valid  = 1'b1;
        exp        = model_resp(req);
      end
      else
      begin
        req.valid = 1'b0;
        exp       = '0;
      end
    end
    @(negedge cpuclk);
    compare_resp(exp, req.pa);                     // Drained
  endtask

  task automatic report_test(input logic [2:0] num);
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("test %0d %s: %s, %0d mismatches", num, test_name[num],
             (test_errors == 0) ? "ok" : "FAILED", test_errors);
    test_errors = 0;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    step_t step;
    reset        = 1'b1;
    apb_req      = '0;
    req          = '0;
    lfsr         = 32'ha240_d01e;
    timed_out    = 1'b0;
    errors       = 0;
    test_errors  = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name[1] = "reset and register map";
    test_name[2] = "TOR ranges";
    test_name[3] = "NAPOT sizes";
    test_name[4] = "priority and permissions";
    test_name[5] = "lock rules";
    test_name[6] = "random pipeline";
    build_table();
    apply_reset();
    for (int s = 0; s < table_q.size() && !timed_out; s++)
    begin
      step = table_q[s];
      case (step.kind)
        K_WR:    apb_write(step.pa[7:0], step.data, step.err);
        K_RD:    apb_read(step.pa[7:0], step.data, step.err);
        default: check_request(step);
      endcase
      if (s == table_q.size() - 1 || table_q[s+1].test != step.test)
        report_test(step.test);                    // Group finished
    end
    if (!timed_out)
    begin
      apply_reset();                               // Clears the locks
      load_model_config();
      run_pipeline();
      report_test(3'd6);
    end
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !timed_out)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule
